// ==== rtl/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address word width
`define XLEN 32

// architectural register file depth, register 0 reads as zero
`define NUM_ARCH_REGS 32

// reorder buffer depth, entries are tagged 1 to ROB_SIZE
`define ROB_SIZE 4

// tag width, tag 0 means "no tag" and is never allocated
`define ROB_TAG_LEN 3

`endif

// ==== rtl/core_types_pkg.sv ====
`include "core_params.svh"

package core_types_pkg;

    // one machine word, used for data and for addresses
    typedef logic [`XLEN-1:0] xlen_t;

    // index into the architectural register file
    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;

    // rename tag, names one reorder buffer slot
    typedef logic [`ROB_TAG_LEN-1:0] rob_tag_t;

endpackage

// ==== rtl/rob_pkg.sv ====
`include "core_params.svh"

package rob_pkg;
    import core_types_pkg::*;

    typedef struct packed {
        logic      valid;
        logic      wr_mem;         // entry is a store
        arch_reg_t dest_reg;
        xlen_t     dest_addr;      // store address, filled from the cdb
        xlen_t     value;          // result, or the data of a store
        rob_tag_t  store_dep;      // producer of the store data
        logic      value_ready;
        logic      address_ready;  // non-stores have no address to wait for
    } rob_entry_t;

    localparam rob_entry_t ROB_EMPTY_ENTRY = '{
        default: '0
    };

endpackage

// ==== rtl/commit_if.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

// head of the reorder buffer as seen by retirement
interface commit_if
    import core_types_pkg::*;
();
    logic      head_ready;     // head retires at the next edge when high
    logic      head_wr_mem;
    arch_reg_t head_dest_reg;
    xlen_t     head_value;
    xlen_t     head_dest_addr;

    modport producer (
        output head_ready, head_wr_mem, head_dest_reg, head_value, head_dest_addr
    );

    modport consumer (
        input head_ready, head_wr_mem, head_dest_reg, head_value, head_dest_addr
    );

endinterface

// ==== rtl/rob.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module rob
    import core_types_pkg::*;
    import rob_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       alloc_enable,
    input  logic       alloc_wr_mem,          // new entry is a store
    input  xlen_t      alloc_value_in,        // store data when known at dispatch
    input  logic       alloc_value_in_valid,
    input  rob_tag_t   alloc_store_dep,       // otherwise the tag producing it
    input  arch_reg_t  dest_reg,
    input  logic       cdb_valid,
    input  rob_tag_t   cdb_rob_tag,
    input  xlen_t      cdb_value,
    input  rob_tag_t   read_rob_tag,
    input  xlen_t      load_address,
    input  rob_tag_t   load_rob_tag,
    output logic       full,
    output rob_tag_t   alloc_slot,
    output logic       alloc_fire,
    output xlen_t      read_value,
    output logic       pending_stores,        // older store to the same address
    output logic       wr_valid,
    output arch_reg_t  wr_dest_reg,
    output rob_tag_t   wr_rob_tag,
    commit_if.producer commit
);

    rob_entry_t entries [1:`ROB_SIZE];
    rob_tag_t   head;
    rob_tag_t   tail;
    rob_entry_t new_entry;
    logic       head_ready;
    logic       cdb_ok;
    logic       cdb_is_store;

    function automatic rob_tag_t next_tag(input rob_tag_t t);
        return (t == rob_tag_t'(`ROB_SIZE)) ? rob_tag_t'(1) : t + rob_tag_t'(1);
    endfunction

    function automatic rob_tag_t prev_tag(input rob_tag_t t);
        return (t == rob_tag_t'(1)) ? rob_tag_t'(`ROB_SIZE) : t - rob_tag_t'(1);
    endfunction

    function automatic logic tag_in_range(input rob_tag_t t);
        return (t != '0) && (t <= rob_tag_t'(`ROB_SIZE));
    endfunction

    assign cdb_ok       = cdb_valid && tag_in_range(cdb_rob_tag);
    assign cdb_is_store = cdb_ok && entries[cdb_rob_tag].wr_mem;  // store gets its address

    // register results only, the map table never holds a store tag
    assign wr_valid    = cdb_ok && !entries[cdb_rob_tag].wr_mem;
    assign wr_dest_reg = entries[cdb_rob_tag].dest_reg;
    assign wr_rob_tag  = cdb_rob_tag;

    assign head_ready = entries[head].valid && entries[head].value_ready &&
                        entries[head].address_ready;

    // a retiring head frees its slot for a dispatch in the same cycle
    assign full       = entries[head].valid && (tail == head) && !head_ready;
    assign alloc_fire = alloc_enable && !full;
    assign alloc_slot = tail;
    assign read_value = tag_in_range(read_rob_tag) ? entries[read_rob_tag].value : '0;

    assign commit.head_ready     = head_ready;
    assign commit.head_wr_mem    = entries[head].wr_mem;
    assign commit.head_dest_reg  = entries[head].dest_reg;
    assign commit.head_value     = entries[head].value;
    assign commit.head_dest_addr = entries[head].dest_addr;

    always_comb begin
        new_entry               = ROB_EMPTY_ENTRY;
        new_entry.valid         = 1'b1;
        new_entry.wr_mem        = alloc_wr_mem;
        new_entry.dest_reg      = dest_reg;
        new_entry.store_dep     = alloc_store_dep;
        new_entry.address_ready = !alloc_wr_mem;
        if (alloc_wr_mem) begin
            new_entry.value       = alloc_value_in;
            new_entry.value_ready = alloc_value_in_valid;
            // producer broadcasting right now, take the value off the cdb
            if (!alloc_value_in_valid && wr_valid && cdb_rob_tag == alloc_store_dep) begin
                new_entry.value       = cdb_value;
                new_entry.value_ready = 1'b1;
            end
        end
    end

    // walk from the slot before the load back to the head
    always_comb begin
        rob_tag_t scan;
        logic     done;
        pending_stores = 1'b0;
        scan           = load_rob_tag;
        done           = !tag_in_range(load_rob_tag) || !entries[load_rob_tag].valid ||
                         (load_rob_tag == head);
        for (int i = 1; i < `ROB_SIZE; i++) begin
            if (!done) begin
                scan = prev_tag(scan);
                if (entries[scan].valid && entries[scan].wr_mem &&
                    entries[scan].address_ready && entries[scan].dest_addr == load_address) begin
                    pending_stores = 1'b1;
                end
                done = (scan == head);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= rob_tag_t'(1);
            tail <= rob_tag_t'(1);
            for (int i = 1; i <= `ROB_SIZE; i++) begin
                entries[i] <= ROB_EMPTY_ENTRY;
            end
        end else begin
            if (cdb_is_store) begin
                entries[cdb_rob_tag].dest_addr     <= cdb_value;
                entries[cdb_rob_tag].address_ready <= 1'b1;
            end else if (wr_valid) begin
                for (int i = 1; i <= `ROB_SIZE; i++) begin
                    if (rob_tag_t'(i) == cdb_rob_tag ||
                        (entries[i].valid && entries[i].wr_mem && !entries[i].value_ready &&
                         entries[i].store_dep == cdb_rob_tag)) begin
                        entries[i].value       <= cdb_value;
                        entries[i].value_ready <= 1'b1;
                    end
                end
            end
            if (head_ready) begin
                entries[head] <= ROB_EMPTY_ENTRY;
                head          <= next_tag(head);
            end
            if (alloc_fire) begin
                entries[tail] <= new_entry;  // overrides the clear when reusing the head
                tail          <= next_tag(tail);
            end
        end
    end

    a_cdb_tag_nonzero: assert property (
        @(posedge clock) disable iff (reset) cdb_valid |-> cdb_rob_tag != '0
    ) else $error("cdb broadcast carries tag 0");

    // a dispatch lands in a free slot, or in the head that leaves this cycle
    a_alloc_free_slot: assert property (
        @(posedge clock) disable iff (reset)
            alloc_fire |-> !entries[tail].valid || (tail == head && head_ready)
    ) else $error("allocation accepted while full");

endmodule

// ==== rtl/map_table.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module map_table
    import core_types_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      alloc_fire,
    input  logic      alloc_wr_mem,
    input  arch_reg_t alloc_dest_reg,
    input  rob_tag_t  alloc_slot,
    input  logic      wr_valid,
    input  arch_reg_t wr_dest_reg,
    input  rob_tag_t  wr_rob_tag,
    input  arch_reg_t src1_reg,
    input  arch_reg_t src2_reg,
    output logic      src1_busy,
    output rob_tag_t  src1_tag,
    output logic      src2_busy,
    output rob_tag_t  src2_tag
);

    logic [`NUM_ARCH_REGS-1:0] busy;
    rob_tag_t                  tags [`NUM_ARCH_REGS];
    logic                      rename;

    // stores have no destination register to rename
    assign rename = alloc_fire && !alloc_wr_mem && (alloc_dest_reg != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
            tags <= '{default: '0};
        end else begin
            // a newer producer may already own the register
            if (wr_valid && busy[wr_dest_reg] && tags[wr_dest_reg] == wr_rob_tag) begin
                busy[wr_dest_reg] <= 1'b0;
            end
            if (rename) begin
                busy[alloc_dest_reg] <= 1'b1;  // same-cycle rename wins
                tags[alloc_dest_reg] <= alloc_slot;
            end
        end
    end

    assign src1_busy = busy[src1_reg];
    assign src1_tag  = tags[src1_reg];
    assign src2_busy = busy[src2_reg];
    assign src2_tag  = tags[src2_reg];

    for (genvar r = 0; r < `NUM_ARCH_REGS; r++) begin : g_busy_chk
        a_busy_tag: assert property (
            @(posedge clock) disable iff (reset) busy[r] |-> tags[r] != '0
        ) else $error("register %0d busy without a tag", r);
    end

endmodule

// ==== rtl/commit_unit.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module commit_unit
    import core_types_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    commit_if.consumer commit,
    input  arch_reg_t  arch_read_reg,
    output xlen_t      arch_read_value,
    output logic       mem_wr_valid,
    output xlen_t      mem_wr_addr,
    output xlen_t      mem_wr_data
);

    xlen_t regs [`NUM_ARCH_REGS];
    logic  reg_write;

    // head_ready means the entry leaves the rob at this same edge
    assign reg_write = commit.head_ready && !commit.head_wr_mem &&
                       (commit.head_dest_reg != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (reg_write) begin
            regs[commit.head_dest_reg] <= commit.head_value;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_wr_valid <= 1'b0;
        end else begin
            mem_wr_valid <= commit.head_ready && commit.head_wr_mem;  // one cycle per store
        end
    end

    always_ff @(posedge clock) begin
        if (commit.head_ready && commit.head_wr_mem) begin
            mem_wr_addr <= commit.head_dest_addr;
            mem_wr_data <= commit.head_value;
        end
    end

    assign arch_read_value = (arch_read_reg == '0) ? '0 : regs[arch_read_reg];

endmodule

// ==== rtl/tomasulo_backend.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module tomasulo_backend
    import core_types_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      alloc_enable,
    input  logic      alloc_wr_mem,
    input  xlen_t     alloc_value_in,
    input  logic      alloc_value_in_valid,
    input  rob_tag_t  alloc_store_dep,
    input  arch_reg_t dest_reg,
    input  logic      cdb_valid,
    input  rob_tag_t  cdb_rob_tag,
    input  xlen_t     cdb_value,
    input  rob_tag_t  read_rob_tag,
    input  xlen_t     load_address,
    input  rob_tag_t  load_rob_tag,
    input  arch_reg_t src1_reg,
    input  arch_reg_t src2_reg,
    input  arch_reg_t arch_read_reg,
    output logic      full,
    output rob_tag_t  alloc_slot,
    output xlen_t     read_value,
    output logic      pending_stores,
    output logic      src1_busy,
    output rob_tag_t  src1_tag,
    output logic      src2_busy,
    output rob_tag_t  src2_tag,
    output xlen_t     arch_read_value,
    output logic      mem_wr_valid,
    output xlen_t     mem_wr_addr,
    output xlen_t     mem_wr_data
);

    logic      alloc_fire;
    logic      wr_valid;
    arch_reg_t wr_dest_reg;
    rob_tag_t  wr_rob_tag;

    commit_if u_commit_if ();

    rob u_rob (
        .clock                (clock),
        .reset                (reset),
        .alloc_enable         (alloc_enable),
        .alloc_wr_mem         (alloc_wr_mem),
        .alloc_value_in       (alloc_value_in),
        .alloc_value_in_valid (alloc_value_in_valid),
        .alloc_store_dep      (alloc_store_dep),
        .dest_reg             (dest_reg),
        .cdb_valid            (cdb_valid),
        .cdb_rob_tag          (cdb_rob_tag),
        .cdb_value            (cdb_value),
        .read_rob_tag         (read_rob_tag),
        .load_address         (load_address),
        .load_rob_tag         (load_rob_tag),
        .full                 (full),
        .alloc_slot           (alloc_slot),
        .alloc_fire           (alloc_fire),
        .read_value           (read_value),
        .pending_stores       (pending_stores),
        .wr_valid             (wr_valid),
        .wr_dest_reg          (wr_dest_reg),
        .wr_rob_tag           (wr_rob_tag),
        .commit               (u_commit_if.producer)
    );

    // the map table ignores the destination of stores itself
    map_table u_map_table (
        .clock          (clock),
        .reset          (reset),
        .alloc_fire     (alloc_fire),
        .alloc_wr_mem   (alloc_wr_mem),
        .alloc_dest_reg (dest_reg),
        .alloc_slot     (alloc_slot),
        .wr_valid       (wr_valid),
        .wr_dest_reg    (wr_dest_reg),
        .wr_rob_tag     (wr_rob_tag),
        .src1_reg       (src1_reg),
        .src2_reg       (src2_reg),
        .src1_busy      (src1_busy),
        .src1_tag       (src1_tag),
        .src2_busy      (src2_busy),
        .src2_tag       (src2_tag)
    );

    commit_unit u_commit_unit (
        .clock           (clock),
        .reset           (reset),
        .commit          (u_commit_if.consumer),
        .arch_read_reg   (arch_read_reg),
        .arch_read_value (arch_read_value),
        .mem_wr_valid    (mem_wr_valid),
        .mem_wr_addr     (mem_wr_addr),
        .mem_wr_data     (mem_wr_data)
    );

endmodule

// ==== dv/rob_model.svh ====
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// reference state, tags run from 1 to ROB_SIZE
logic        m_valid  [1:`ROB_SIZE];
logic        m_store  [1:`ROB_SIZE];
int          m_dest   [1:`ROB_SIZE];
logic [31:0] m_addr   [1:`ROB_SIZE];
logic [31:0] m_value  [1:`ROB_SIZE];
int          m_dep    [1:`ROB_SIZE];
logic        m_vready [1:`ROB_SIZE];
logic        m_aready [1:`ROB_SIZE];
int          m_head;
int          m_tail;
logic        m_busy [`NUM_ARCH_REGS];
int          m_tag  [`NUM_ARCH_REGS];
logic [31:0] m_regs [`NUM_ARCH_REGS];
logic        m_mem_valid;  // store write due in the current cycle
logic [31:0] m_mem_addr;
logic [31:0] m_mem_data;
int          m_last_dest;  // register written by the last retirement, -1 if none
int          m_retired;

function automatic int wrap_next(input int t);
    return (t == `ROB_SIZE) ? 1 : t + 1;
endfunction

function automatic int wrap_prev(input int t);
    return (t == 1) ? `ROB_SIZE : t - 1;
endfunction

task automatic clear_entry(input int t);
    m_valid[t]  = 1'b0;
    m_store[t]  = 1'b0;
    m_dest[t]   = 0;
    m_addr[t]   = '0;
    m_value[t]  = '0;
    m_dep[t]    = 0;
    m_vready[t] = 1'b0;
    m_aready[t] = 1'b0;
endtask

task automatic model_reset();
    for (int t = 1; t <= `ROB_SIZE; t++) begin
        clear_entry(t);
    end
    for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
        m_busy[r] = 1'b0;
        m_tag[r]  = 0;
        m_regs[r] = '0;
    end
    m_head      = 1;
    m_tail      = 1;
    m_mem_valid = 1'b0;
    m_mem_addr  = '0;
    m_mem_data  = '0;
    m_last_dest = -1;
    m_retired   = 0;
endtask

function automatic logic model_head_ready();
    return m_valid[m_head] && m_vready[m_head] && m_aready[m_head];
endfunction

// four live entries and the head not leaving this cycle
function automatic logic model_full();
    int live;
    live = 0;
    for (int t = 1; t <= `ROB_SIZE; t++) begin
        if (m_valid[t]) begin
            live++;
        end
    end
    return (live == `ROB_SIZE) && !model_head_ready();
endfunction

// older stores only, from the slot before the load back to the head
function automatic logic model_pending(input int load_tag, input logic [31:0] addr);
    int t;
    if (load_tag < 1 || load_tag > `ROB_SIZE || !m_valid[load_tag] || load_tag == m_head) begin
        return 1'b0;
    end
    t = load_tag;
    while (t != m_head) begin
        t = wrap_prev(t);
        if (m_valid[t] && m_store[t] && m_aready[t] && m_addr[t] == addr) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

// advance the model by one rising edge with the inputs driven in this cycle
task automatic model_step(input logic alloc_en, input logic is_store,
                          input logic [31:0] val_in, input logic val_valid,
                          input int dep, input int dreg, input logic cdb_v,
                          input int cdb_tag, input logic [31:0] cdb_val);
    logic retire;
    logic fire;
    logic cdb_reg;
    int   wb_reg;
    int   h;
    int   t;
    retire  = model_head_ready();
    fire    = alloc_en && !model_full();
    cdb_reg = 1'b0;
    wb_reg  = 0;
    if (cdb_v) begin
        cdb_reg = !m_store[cdb_tag];
        wb_reg  = m_dest[cdb_tag];
    end
    h = m_head;
    t = m_tail;

    m_mem_valid = retire && m_store[h];  // pulse seen in the next cycle
    m_mem_addr  = m_addr[h];
    m_mem_data  = m_value[h];
    m_last_dest = -1;
    if (retire && !m_store[h] && m_dest[h] != 0) begin
        m_regs[m_dest[h]] = m_value[h];
        m_last_dest       = m_dest[h];
    end

    // a superseded tag leaves the register busy
    if (cdb_reg && m_busy[wb_reg] && m_tag[wb_reg] == cdb_tag) begin
        m_busy[wb_reg] = 1'b0;
    end
    if (fire && !is_store && dreg != 0) begin
        m_busy[dreg] = 1'b1;
        m_tag[dreg]  = t;
    end

    if (cdb_v && !cdb_reg) begin
        m_addr[cdb_tag]   = cdb_val;  // store address
        m_aready[cdb_tag] = 1'b1;
    end else if (cdb_reg) begin
        m_value[cdb_tag]  = cdb_val;
        m_vready[cdb_tag] = 1'b1;
        for (int i = 1; i <= `ROB_SIZE; i++) begin
            if (m_valid[i] && m_store[i] && !m_vready[i] && m_dep[i] == cdb_tag) begin
                m_value[i]  = cdb_val;
                m_vready[i] = 1'b1;
            end
        end
    end

    if (retire) begin
        clear_entry(h);
        m_head = wrap_next(h);
        m_retired++;
    end
    if (fire) begin
        m_valid[t]  = 1'b1;
        m_store[t]  = is_store;
        m_dest[t]   = dreg;
        m_addr[t]   = '0;
        m_dep[t]    = dep;
        m_aready[t] = !is_store;
        m_value[t]  = is_store ? val_in : '0;
        m_vready[t] = is_store && val_valid;
        // producer broadcasting in the same cycle hands its result straight over
        if (is_store && !val_valid && cdb_reg && cdb_tag == dep) begin
            m_value[t]  = cdb_val;
            m_vready[t] = 1'b1;
        end
        m_tail = wrap_next(t);
    end
endtask

`endif

// ==== dv/tb_tomasulo_backend.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module tb_tomasulo_backend
    import core_types_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int FILL_CYCLES  = 150;
    localparam int MIX_CYCLES   = 400;
    localparam int DRAIN_MAX    = 40;
    localparam int SWEEP_REGS   = 8;
    localparam int TOTAL_CYCLES = RESET_CYCLES + FILL_CYCLES + MIX_CYCLES + DRAIN_MAX +
                                  SWEEP_REGS + 4;
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * 4 + 100;

    logic      clock;
    logic      reset;
    logic      alloc_enable;
    logic      alloc_wr_mem;
    xlen_t     alloc_value_in;
    logic      alloc_value_in_valid;
    rob_tag_t  alloc_store_dep;
    arch_reg_t dest_reg;
    logic      cdb_valid;
    rob_tag_t  cdb_rob_tag;
    xlen_t     cdb_value;
    rob_tag_t  read_rob_tag;
    xlen_t     load_address;
    rob_tag_t  load_rob_tag;
    arch_reg_t src1_reg;
    arch_reg_t src2_reg;
    arch_reg_t arch_read_reg;
    logic      full;
    rob_tag_t  alloc_slot;
    xlen_t     read_value;
    logic      pending_stores;
    logic      src1_busy;
    rob_tag_t  src1_tag;
    logic      src2_busy;
    rob_tag_t  src2_tag;
    xlen_t     arch_read_value;
    logic      mem_wr_valid;
    xlen_t     mem_wr_addr;
    xlen_t     mem_wr_data;

    logic [31:0] lcg_state = 32'd62907;
    int          errors    = 0;
    int          checks    = 0;
    int          held      = 0;  // dispatches refused while full
    int          stores_out = 0;
    int          fwd_same  = 0;  // stores that caught their data at allocation

    `include "rob_model.svh"

    tomasulo_backend u_dut (.*);

    always #2 clock = ~clock;

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand_word() >> 16) % n;  // upper bits, the low ones cycle fast
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        checks++;
        if (got !== expected) begin
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    // one cycle of dispatch, cdb and queries, a sweep_reg >= 0 pins the lookups
    task automatic run_cycle(input int dispatch_pct, input int cdb_pct, input int sweep_reg);
        int          cands [$];
        int          deps [$];
        logic        do_cdb;
        int          ctag;
        logic [31:0] cval;
        logic        do_alloc;
        logic        st;
        logic        vval;
        logic [31:0] vin;
        int          dep;
        int          dreg;
        int          rt;
        int          lt;
        logic [31:0] la;
        int          s1;
        int          s2;
        int          ar;
        @(negedge clock);
        for (int t = 1; t <= `ROB_SIZE; t++) begin
            if (m_valid[t] && (m_store[t] ? !m_aready[t] : !m_vready[t])) begin
                cands.push_back(t);
            end
            if (m_valid[t] && !m_store[t] && !m_vready[t]) begin
                deps.push_back(t);
            end
        end
        do_cdb = (cands.size() > 0) && (rand_below(100) < cdb_pct);
        ctag   = 0;
        cval   = rand_word();
        if (do_cdb) begin
            ctag = cands[rand_below(cands.size())];
            if (m_store[ctag]) begin
                cval = rand_below(4) * 4;  // few addresses so loads hit stores
            end
        end
        do_alloc = (sweep_reg < 0) && (rand_below(100) < dispatch_pct);
        st       = rand_below(100) < 35;
        vin      = rand_word();
        dreg     = rand_below(8);  // small range so renames collide
        vval     = st;
        dep      = 0;
        if (st && deps.size() > 0 && rand_below(2) == 0) begin
            vval = 1'b0;
            if (do_cdb && !m_store[ctag] && rand_below(2) == 0) begin
                dep = ctag;
            end else begin
                dep = deps[rand_below(deps.size())];
            end
        end
        rt = 1 + rand_below(`ROB_SIZE);
        lt = 1 + rand_below(`ROB_SIZE);
        la = rand_below(4) * 4;
        s1 = (sweep_reg >= 0) ? sweep_reg : rand_below(8);
        s2 = (sweep_reg >= 0) ? sweep_reg : rand_below(8);
        ar = (sweep_reg >= 0) ? sweep_reg : ((m_last_dest > 0) ? m_last_dest : rand_below(8));

        alloc_enable         = do_alloc;
        alloc_wr_mem         = st;
        alloc_value_in       = vin;
        alloc_value_in_valid = vval;
        alloc_store_dep      = rob_tag_t'(dep);
        dest_reg             = arch_reg_t'(dreg);
        cdb_valid            = do_cdb;
        cdb_rob_tag          = rob_tag_t'(ctag);
        cdb_value            = cval;
        read_rob_tag         = rob_tag_t'(rt);
        load_rob_tag         = rob_tag_t'(lt);
        load_address         = la;
        src1_reg             = arch_reg_t'(s1);
        src2_reg             = arch_reg_t'(s2);
        arch_read_reg        = arch_reg_t'(ar);

        #1;  // outputs settle well before the rising edge
        check_value(32'(full), 32'(model_full()), "full");
        check_value(32'(alloc_slot), 32'(m_tail), "alloc_slot");
        if (m_valid[rt]) begin
            check_value(read_value, m_value[rt], "read_value");
        end
        check_value(32'(pending_stores), 32'(model_pending(lt, la)), "pending_stores");
        check_value(32'(src1_busy), 32'(m_busy[s1]), "src1_busy");
        if (m_busy[s1]) begin
            check_value(32'(src1_tag), 32'(m_tag[s1]), "src1_tag");
        end
        check_value(32'(src2_busy), 32'(m_busy[s2]), "src2_busy");
        if (m_busy[s2]) begin
            check_value(32'(src2_tag), 32'(m_tag[s2]), "src2_tag");
        end
        check_value(arch_read_value, m_regs[ar], "arch_read_value");
        check_value(32'(mem_wr_valid), 32'(m_mem_valid), "mem_wr_valid");
        if (m_mem_valid) begin
            check_value(mem_wr_addr, m_mem_addr, "mem_wr_addr");
            check_value(mem_wr_data, m_mem_data, "mem_wr_data");
            stores_out++;
        end
        if (sweep_reg >= 0) begin
            check_value(32'(src1_busy), 32'd0, "busy bit after drain");
        end
        if (do_alloc && model_full()) begin
            held++;
        end
        if (do_alloc && !model_full() && st && !vval && do_cdb && dep == ctag) begin
            fwd_same++;
        end
        model_step(do_alloc, st, vin, vval, dep, dreg, do_cdb, ctag, cval);
    endtask

    task automatic run_test(input string name, input int cycles, input int dispatch_pct,
                            input int cdb_pct);
        int err0;
        err0       = errors;
        held       = 0;
        stores_out = 0;
        repeat (cycles) run_cycle(dispatch_pct, cdb_pct, -1);
        $display("test %s: %0d cycles, %0d stores written, %0d dispatches held, %0d errors",
                 name, cycles, stores_out, held, errors - err0);
    endtask

    // broadcast everything outstanding until the last store pulse is seen
    task automatic drain_rob();
        int n;
        n = 0;
        while ((m_valid[m_head] || m_mem_valid) && n < DRAIN_MAX) begin
            run_cycle(0, 100, -1);
            n++;
        end
        if (m_valid[m_head] || m_mem_valid) begin
            $display("drain: reorder buffer still holds entries after %0d cycles", n);
            errors++;
        end
        $display("test drain: %0d cycles, %0d errors so far", n, errors);
    endtask

    initial begin
        clock                = 1'b0;
        reset                = 1'b1;
        alloc_enable         = 1'b0;
        alloc_wr_mem         = 1'b0;
        alloc_value_in       = '0;
        alloc_value_in_valid = 1'b0;
        alloc_store_dep      = '0;
        dest_reg             = '0;
        cdb_valid            = 1'b0;
        cdb_rob_tag          = '0;
        cdb_value            = '0;
        read_rob_tag         = '0;
        load_address         = '0;
        load_rob_tag         = '0;
        src1_reg             = '0;
        src2_reg             = '0;
        arch_read_reg        = '0;
        model_reset();
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;

        run_test("fill", FILL_CYCLES, 80, 20);  // mostly dispatch, hits full often
        run_test("mixed", MIX_CYCLES, 50, 55);
        drain_rob();
        for (int r = 0; r < SWEEP_REGS; r++) begin
            run_cycle(0, 0, r);
        end
        $display("test sweep: %0d registers read back, %0d errors so far", SWEEP_REGS, errors);

        $display("summary: %0d checks, %0d errors, %0d retired, %0d same-cycle forwards",
                 checks, errors, m_retired, fwd_same);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the simulation ran past its cycle budget");
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== tomasulo_backend.f ====
+incdir+rtl
+incdir+dv
rtl/core_types_pkg.sv
rtl/rob_pkg.sv
rtl/commit_if.sv
rtl/rob.sv
rtl/map_table.sv
rtl/commit_unit.sv
rtl/tomasulo_backend.sv
dv/tb_tomasulo_backend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the run by its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tomasulo_backend.f \
    --top-module tb_tomasulo_backend -o tb_sim &&
    ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Verification passed" &&
    echo "run_sim: PASS" ||
    { echo "run_sim: FAIL"; exit 1; }
